/* Makefile */
SIM        ?= verilator
TOP        ?= tb_tmr_scratchpad
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/scratch_patterns.hex */
// op _ address _ sel _ data _ fault copy _ fault mask _ expected data _ expected err count
// op 0 write, 1 read, 2 burst read (data = word count), 3 out-of-range write and read
0_00000010_f_11223344_0_00000000_00000000_0000
1_00000010_f_00000000_0_00000000_11223344_0000
0_00000010_5_aabbccdd_0_00000000_00000000_0000
1_00000010_f_00000000_0_00000000_11bb33dd_0000
0_00000010_a_55667788_0_00000000_00000000_0000
1_00000010_f_00000000_0_00000000_55bb77dd_0000
0_00000020_1_000000ee_0_00000000_00000000_0000
1_00000020_f_00000000_0_00000000_000000ee_0000
0_00000100_f_cafef00d_1_0000ffff_00000000_0000
1_00000100_f_00000000_0_00000000_cafef00d_0001
1_00000100_f_00000000_0_00000000_cafef00d_0002
0_00000104_f_0badbeef_2_ffffffff_00000000_0002
1_00000104_f_00000000_0_00000000_0badbeef_0003
0_00000108_f_12345678_3_80000001_00000000_0003
1_00000108_f_00000000_0_00000000_12345678_0004
1_00000010_f_00000000_0_00000000_55bb77dd_0004
0_0000010c_3_0000a5a5_2_00ff00ff_00000000_0004
1_0000010c_f_00000000_0_00000000_0000a5a5_0005
2_00000400_f_00000008_0_00000000_00000000_0005
2_00003ff0_f_00000004_0_00000000_00000000_0005
3_00004010_f_deadbeef_0_00000000_00000000_0005
1_00000010_f_00000000_0_00000000_55bb77dd_0005
3_80000100_f_ffffffff_0_00000000_00000000_0005
1_00000100_f_00000000_0_00000000_cafef00d_0006
1_00000020_f_00000000_0_00000000_000000ee_0006

/* dv/tb_tmr_scratchpad.sv */
`include "scratch_defines.svh"

module tb_tmr_scratchpad
	import scratch_bus_pkg::*;
	import scratch_tmr_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// ==============================
	// run constants
	// ==============================

	// operation codes from the first column of the pattern file
	localparam logic [3:0] OP_WRITE  = 4'h0;
	localparam logic [3:0] OP_READ   = 4'h1;
	localparam logic [3:0] OP_BURST  = 4'h2;
	localparam logic [3:0] OP_DECODE = 4'h3;
	localparam logic [3:0] OP_END    = 4'hf;

	localparam int MAX_PATTERNS   = 64;
	// read ack arrives in the third cycle of the select
	localparam int READ_LATENCY   = 3;
	localparam int ACK_WAIT_LIMIT = 8;
	localparam int NO_ACK_CYCLES  = 6;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      cyc;
	logic      stb;
	logic      we;
	byte_sel_t sel;
	bus_addr_t adr;
	bus_data_t wdata;
	logic      ack;
	bus_data_t rdata;
	copy_sel_t fault_copy;
	bus_data_t fault_mask;
	err_cnt_t  err_cnt;

	// one 156-bit word per pattern line
	logic [155:0] patterns [MAX_PATTERNS];
	// expected contents as written on the bus
	bus_data_t    model_mem [`SCRATCH_DEPTH];
	logic [31:0]  lfsr_state;
	int           watchdog_cycles;

	// 100 ns clock
	always #50 clk = ~clk;

	tmr_scratchpad tmr_scratchpad_inst (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.cyc_i        (cyc),
		.stb_i        (stb),
		.we_i         (we),
		.sel_i        (sel),
		.adr_i        (adr),
		.dat_i        (wdata),
		.ack_o        (ack),
		.dat_o        (rdata),
		.fault_copy_i (fault_copy),
		.fault_mask_i (fault_mask),
		.err_cnt_o    (err_cnt)
	);

	// ==============================
	// helpers and checks
	// ==============================

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s data expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_err_cnt(input string name, input err_cnt_t exp, input err_cnt_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s err_cnt expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic check_ack(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s ack expected %b actual %b", name, exp, act));
		end
	endtask

	// galois form with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h8020_0003;
		end
		return next;
	endfunction

	// one step per bit with the lsb out first
	task automatic random_word(output bus_data_t word);
		word = '0;
		for (int b = 0; b < 32; b++) begin
			word = {lfsr_state[0], word[31:1]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// selected byte lanes of the new word replace those of the old one
	function automatic bus_data_t merge_lanes(input bus_data_t old_word,
		input bus_data_t new_word, input byte_sel_t lanes);
		bus_data_t merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	task automatic release_bus();
		cyc        <= 1'b0;
		stb        <= 1'b0;
		we         <= 1'b0;
		sel        <= '0;
		adr        <= '0;
		wdata      <= '0;
		fault_copy <= '0;
		fault_mask <= '0;
	endtask

	task automatic drive_cycle(input logic wr, input bus_addr_t a, input byte_sel_t s,
		input bus_data_t d, input copy_sel_t fc, input bus_data_t fm);
		cyc        <= 1'b1;
		stb        <= 1'b1;
		we         <= wr;
		sel        <= s;
		adr        <= a;
		wdata      <= d;
		fault_copy <= fc;
		fault_mask <= fm;
	endtask

	// ==============================
	// bus operations
	// ==============================

	// single write with the ack expected in the same cycle
	task automatic write_word(input string name, input bus_addr_t a, input byte_sel_t s,
		input bus_data_t d, input copy_sel_t fc, input bus_data_t fm);
		word_idx_t idx;
		idx = a[`SCRATCH_DECODE_LSB-1:2];
		@(posedge clk);
		drive_cycle(1'b1, a, s, d, fc, fm);
		@(negedge clk);
		check_ack(name, 1'b1, ack);
		@(posedge clk);
		release_bus();
		model_mem[idx] = merge_lanes(model_mem[idx], d, s);
	endtask

	// hold a read select until ack and check how long it took
	task automatic wait_read_ack(input string name);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ack && cycles < ACK_WAIT_LIMIT);
		if (!ack) begin
			abort_run($sformatf("%s got no acknowledge within %0d cycles", name, cycles));
		end
		if (cycles != READ_LATENCY) begin
			abort_run($sformatf("%s was acknowledged in cycle %0d, not in cycle %0d",
				name, cycles, READ_LATENCY));
		end
	endtask

	// drop the select and expect dat_o back at zero one edge later
	task automatic finish_read(input string name, input err_cnt_t exp_cnt);
		@(posedge clk);
		release_bus();
		@(posedge clk);
		@(negedge clk);
		check_data({name, " idle"}, '0, rdata);
		check_err_cnt(name, exp_cnt, err_cnt);
	endtask

	task automatic read_word(input string name, input bus_addr_t a, input bus_data_t exp,
		input err_cnt_t exp_cnt);
		@(posedge clk);
		drive_cycle(1'b0, a, 4'hf, '0, '0, '0);
		wait_read_ack(name);
		check_data(name, exp, rdata);
		finish_read(name, exp_cnt);
	endtask

	// fill n words from the lfsr and read them back in one held select
	task automatic burst_read(input string name, input bus_addr_t a, input int n,
		input err_cnt_t exp_cnt);
		bus_data_t word;
		word_idx_t start;
		start = a[`SCRATCH_DECODE_LSB-1:2];
		for (int k = 0; k < n; k++) begin
			random_word(word);
			write_word({name, " fill"}, a + bus_addr_t'(4 * k), 4'hf, word, '0, '0);
		end
		@(posedge clk);
		drive_cycle(1'b0, a, 4'hf, '0, '0, '0);
		wait_read_ack(name);
		for (int k = 0; k < n; k++) begin
			if (k > 0) begin
				@(negedge clk);
				check_ack($sformatf("%s word %0d", name, k), 1'b1, ack);
			end
			check_data($sformatf("%s word %0d", name, k),
				model_mem[start + word_idx_t'(k)], rdata);
		end
		finish_read(name, exp_cnt);
	endtask

	// write and read above 16 KiB where neither may be acknowledged
	task automatic decode_probe(input string name, input bus_addr_t a, input bus_data_t d,
		input err_cnt_t exp_cnt);
		@(posedge clk);
		drive_cycle(1'b1, a, 4'hf, d, '0, '0);
		repeat (NO_ACK_CYCLES) begin
			@(negedge clk);
			check_ack({name, " write"}, 1'b0, ack);
		end
		@(posedge clk);
		release_bus();
		@(posedge clk);
		drive_cycle(1'b0, a, 4'hf, '0, '0, '0);
		repeat (NO_ACK_CYCLES) begin
			@(negedge clk);
			check_ack({name, " read"}, 1'b0, ack);
		end
		finish_read(name, exp_cnt);
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin : stimulus
		logic [155:0] pat;
		string        name;
		int           n_lines;
		int           burst_total;

		release_bus();
		rst_n <= 1'b0;
		lfsr_state = 32'h9d24;
		for (int i = 0; i < `SCRATCH_DEPTH; i++) begin
			model_mem[i] = '0;
		end
		// lines missing from the file read as end markers
		for (int i = 0; i < MAX_PATTERNS; i++) begin
			patterns[i] = {OP_END, 152'b0};
		end
		$readmemh("dv/scratch_patterns.hex", patterns);
		n_lines = 0;
		burst_total = 0;
		while (n_lines < MAX_PATTERNS && patterns[n_lines][155:152] != OP_END) begin
			if (patterns[n_lines][155:152] == OP_BURST) begin
				burst_total += int'(patterns[n_lines][115:84]);
			end
			n_lines++;
		end
		watchdog_cycles = n_lines * 40 + burst_total * 4;
		if (n_lines == 0) begin
			abort_run("no operations found in dv/scratch_patterns.hex");
		end

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_ack("after reset", 1'b0, ack);
		check_data("after reset", '0, rdata);
		check_err_cnt("after reset", '0, err_cnt);

		for (int i = 0; i < n_lines; i++) begin
			pat = patterns[i];
			name = $sformatf("pattern %0d", i + 1);
			case (pat[155:152])
				OP_WRITE: begin
					write_word(name, pat[151:120], pat[119:116], pat[115:84], pat[81:80],
						pat[79:48]);
					@(negedge clk);
					check_err_cnt(name, pat[15:0], err_cnt);
				end
				OP_READ:   read_word(name, pat[151:120], pat[47:16], pat[15:0]);
				OP_BURST:  burst_read(name, pat[151:120], int'(pat[115:84]), pat[15:0]);
				OP_DECODE: decode_probe(name, pat[151:120], pat[115:84], pat[15:0]);
				default:   abort_run({name, " has an unknown operation code"});
			endcase
		end

		$display("Simulation passed");
		$finish;
	end

	// bound on the whole run sized from the pattern file
	initial begin : watchdog
		#1;
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, bus operations never completed",
			watchdog_cycles);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

endmodule

/* filelist.f */
+incdir+include
rtl/scratch_bus_pkg.sv
rtl/scratch_tmr_pkg.sv
rtl/scratch_bus_frontend.sv
rtl/tmr_mem_array.sv
rtl/tmr_voter.sv
rtl/tmr_scratchpad.sv
dv/tb_tmr_scratchpad.sv

/* include/scratch_defines.svh */
`ifndef SCRATCH_DEFINES_SVH
`define SCRATCH_DEFINES_SVH

// ==============================
// memory geometry
// ==============================

// word index bits, 4096 words of 32 bits = 16 KiB
`define SCRATCH_WORD_IDX_W 12
// number of words held in each copy
`define SCRATCH_DEPTH (1 << `SCRATCH_WORD_IDX_W)
// lowest address bit that must be zero for a chip select
`define SCRATCH_DECODE_LSB 14

// ==============================
// redundancy
// ==============================

// per-byte storage masks of copies 1 and 2 (copy 0 is unmasked)
`define SCRATCH_MASK1 8'hAA
`define SCRATCH_MASK2 8'h55
// width of the disagreement counter
`define SCRATCH_ERR_CNT_W 16

`endif

/* rtl/scratch_bus_frontend.sv */
`include "scratch_defines.svh"

module scratch_bus_frontend
	import scratch_bus_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      cyc_i,
	input  logic      stb_i,
	input  logic      we_i,
	input  bus_addr_t adr_i,
	input  byte_sel_t sel_i,
	output logic      ack_o,
	output logic      wr_en_o,
	output byte_sel_t wr_sel_o,
	output word_idx_t wr_idx_o,
	output word_idx_t rd_idx_o,
	output logic      rd_cs_o,
	output logic      vote_en_o
);

	// ==============================
	// address decode
	// ==============================

	logic      cs;
	logic      cs_rise;
	word_idx_t adr_idx;

	// only the lowest 16 KiB answers
	assign cs = cyc_i & stb_i & (adr_i[31:`SCRATCH_DECODE_LSB] == '0);
	assign adr_idx = adr_i[`SCRATCH_DECODE_LSB-1:2];

	// ==============================
	// read pipeline
	// ==============================

	logic      rd_stage1_q;
	logic      rd_stage2_q;
	word_idx_t burst_ctr_q;
	word_idx_t rd_idx_q;

	// stage 1 is the select delayed by one cycle
	// it doubles as the reference for the rising edge
	assign cs_rise = cs & ~rd_stage1_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rd_stage1_q <= 1'b0;
			rd_stage2_q <= 1'b0;
			burst_ctr_q <= '0;
			rd_idx_q    <= '0;
		end else begin
			rd_stage1_q <= cs;
			// stage 2 only survives while the select is still held
			rd_stage2_q <= rd_stage1_q & cs;
			// burst counter runs one word ahead of the read index
			if (cs_rise) begin
				burst_ctr_q <= adr_idx + word_idx_t'(1);
			end else if (cs) begin
				burst_ctr_q <= burst_ctr_q + word_idx_t'(1);
			end
			// first word straight from the bus and later ones from the counter
			rd_idx_q <= cs_rise ? adr_idx : burst_ctr_q;
		end
	end

	// ==============================
	// outputs
	// ==============================

	// writes ack in the same cycle and reads once stage 2 is set
	assign ack_o = cs & (we_i | rd_stage2_q);
	// voted word on dat_o is being acknowledged this cycle
	assign vote_en_o = cs & ~we_i & rd_stage2_q;

	assign wr_en_o  = cs & we_i;
	assign wr_sel_o = sel_i;
	assign wr_idx_o = adr_idx;
	assign rd_idx_o = rd_idx_q;
	assign rd_cs_o  = cs;

	// a read ack only follows a select held over the two edges before
	a_read_ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ack_o && !we_i) |-> ($past(cs) && $past(cs, 2)));

	// inside a held select the read index steps by exactly one word
	a_burst_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(cs && rd_stage1_q) |=> (rd_idx_q == $past(rd_idx_q) + word_idx_t'(1)));

endmodule

/* rtl/scratch_bus_pkg.sv */
`include "scratch_defines.svh"

package scratch_bus_pkg;

	// ==============================
	// bus side types
	// ==============================

	// byte address as seen on the bus
	typedef logic [31:0] bus_addr_t;

	// one data word, four byte lanes
	typedef logic [31:0] bus_data_t;

	// byte-lane enables, bit n covers bits 8n+7..8n
	typedef logic [3:0] byte_sel_t;

	// word index inside the scratchpad
	// taken from address bits 13..2
	typedef logic [`SCRATCH_WORD_IDX_W-1:0] word_idx_t;

endpackage

/* rtl/scratch_tmr_pkg.sv */
`include "scratch_defines.svh"

package scratch_tmr_pkg;

	// ==============================
	// redundancy types
	// ==============================

	// copy that takes the fault mask on a write
	// 0 = no copy, 1..3 = copy 0..2
	typedef logic [1:0] copy_sel_t;

	// saturating count of voted reads with disagreeing copies
	typedef logic [`SCRATCH_ERR_CNT_W-1:0] err_cnt_t;

endpackage

/* rtl/tmr_mem_array.sv */
`include "scratch_defines.svh"

module tmr_mem_array
	import scratch_bus_pkg::*;
	import scratch_tmr_pkg::*;
(
	input  logic      clk_i,
	input  logic      wr_en_i,
	input  byte_sel_t wr_sel_i,
	input  word_idx_t wr_idx_i,
	input  word_idx_t rd_idx_i,
	input  bus_data_t wr_data_i,
	input  copy_sel_t fault_copy_i,
	input  bus_data_t fault_mask_i,
	output bus_data_t word0_o,
	output bus_data_t word1_o,
	output bus_data_t word2_o
);

	// raw stored words of the three copies at the read index
	bus_data_t rd_word [3];

	// ==============================
	// one block per copy
	// ==============================

	for (genvar c = 0; c < 3; c++) begin : g_copy
		// storage mask of this copy
		localparam bus_data_t COPY_MASK = (c == 1) ? {4{`SCRATCH_MASK1}} :
			(c == 2) ? {4{`SCRATCH_MASK2}} : '0;

		bus_data_t mem [`SCRATCH_DEPTH];
		bus_data_t fault_xor;
		bus_data_t wr_word;

		// each copy holds its own mask, so every word reads back as zero
		initial begin
			for (int i = 0; i < `SCRATCH_DEPTH; i++) begin
				mem[i] = COPY_MASK;
			end
		end

		// fault mask lands only in the selected copy
		assign fault_xor = (fault_copy_i == copy_sel_t'(c + 1)) ? fault_mask_i : '0;
		assign wr_word = wr_data_i ^ COPY_MASK ^ fault_xor;

		// byte-lane write
		always_ff @(posedge clk_i) begin
			if (wr_en_i) begin
				for (int b = 0; b < 4; b++) begin
					if (wr_sel_i[b]) begin
						mem[wr_idx_i][b*8 +: 8] <= wr_word[b*8 +: 8];
					end
				end
			end
		end

		// asynchronous read, the front end already registered the index
		assign rd_word[c] = mem[rd_idx_i];
	end

	assign word0_o = rd_word[0];
	assign word1_o = rd_word[1];
	assign word2_o = rd_word[2];

	// an unknown copy select would corrupt a copy silently
	a_fault_sel_known: assert property (@(posedge clk_i)
		wr_en_i |-> !$isunknown(fault_copy_i));

endmodule

/* rtl/tmr_scratchpad.sv */
module tmr_scratchpad
	import scratch_bus_pkg::*;
	import scratch_tmr_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_n_i,
	// bus slave
	input  logic      cyc_i,
	input  logic      stb_i,
	input  logic      we_i,
	input  byte_sel_t sel_i,
	input  bus_addr_t adr_i,
	input  bus_data_t dat_i,
	output logic      ack_o,
	output bus_data_t dat_o,
	// fault injection
	input  copy_sel_t fault_copy_i,
	input  bus_data_t fault_mask_i,
	// status
	output err_cnt_t  err_cnt_o
);

	logic      wr_en;
	byte_sel_t wr_sel;
	word_idx_t wr_idx;
	word_idx_t rd_idx;
	logic      rd_cs;
	logic      vote_en;
	bus_data_t word0;
	bus_data_t word1;
	bus_data_t word2;

	// bus decode, ack and read index
	scratch_bus_frontend frontend_inst (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.adr_i     (adr_i),
		.sel_i     (sel_i),
		.ack_o     (ack_o),
		.wr_en_o   (wr_en),
		.wr_sel_o  (wr_sel),
		.wr_idx_o  (wr_idx),
		.rd_idx_o  (rd_idx),
		.rd_cs_o   (rd_cs),
		.vote_en_o (vote_en)
	);

	// three masked copies
	tmr_mem_array mem_array_inst (
		.clk_i        (clk_i),
		.wr_en_i      (wr_en),
		.wr_sel_i     (wr_sel),
		.wr_idx_i     (wr_idx),
		.rd_idx_i     (rd_idx),
		.wr_data_i    (dat_i),
		.fault_copy_i (fault_copy_i),
		.fault_mask_i (fault_mask_i),
		.word0_o      (word0),
		.word1_o      (word1),
		.word2_o      (word2)
	);

	// vote, read data register, disagreement count
	tmr_voter voter_inst (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.rd_cs_i   (rd_cs),
		.vote_en_i (vote_en),
		.word0_i   (word0),
		.word1_i   (word1),
		.word2_i   (word2),
		.dat_o     (dat_o),
		.err_cnt_o (err_cnt_o)
	);

endmodule

/* rtl/tmr_voter.sv */
`include "scratch_defines.svh"

module tmr_voter
	import scratch_bus_pkg::*;
	import scratch_tmr_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      rd_cs_i,
	input  logic      vote_en_i,
	input  bus_data_t word0_i,
	input  bus_data_t word1_i,
	input  bus_data_t word2_i,
	output bus_data_t dat_o,
	output err_cnt_t  err_cnt_o
);

	localparam bus_data_t UNMASK1 = {4{`SCRATCH_MASK1}};
	localparam bus_data_t UNMASK2 = {4{`SCRATCH_MASK2}};

	// ==============================
	// majority vote
	// ==============================

	bus_data_t w0;
	bus_data_t w1;
	bus_data_t w2;
	bus_data_t vote;
	logic      disagree;
	logic      disagree_q;

	assign w0 = word0_i;
	assign w1 = word1_i ^ UNMASK1;
	assign w2 = word2_i ^ UNMASK2;

	// bitwise two-out-of-three
	assign vote = (w0 & w1) | (w0 & w2) | (w1 & w2);
	// any copy off the vote means the copies are not all equal
	assign disagree = (w0 != w1) | (w1 != w2);

	// ==============================
	// read data and error count
	// ==============================

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			dat_o      <= '0;
			disagree_q <= 1'b0;
			err_cnt_o  <= '0;
		end else begin
			// data bus idles at zero outside a select
			dat_o      <= rd_cs_i ? vote : '0;
			// mismatch flag travels with the word on dat_o
			disagree_q <= rd_cs_i & disagree;
			// count only words that the bus actually takes and saturate at the top
			if (vote_en_i && disagree_q && (err_cnt_o != '1)) begin
				err_cnt_o <= err_cnt_o + err_cnt_t'(1);
			end
		end
	end

	// a copy that lost the vote must show up as a disagreement
	a_vote_flags_loser: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		((vote != w0) || (vote != w1) || (vote != w2)) |-> disagree);

endmodule
